// File: build.f
rtl/axi_types_pkg.sv
rtl/conv_cfg_pkg.sv
rtl/aw_burst_splitter.sv
rtl/w_cmd_queue.sv
rtl/w_axi3_conv.sv
rtl/b_resp_merger.sv
rtl/axi4_to_axi3_wr.sv
tests/wr_conv_checker.sv
tests/tb_axi4_to_axi3_wr.sv

// File: Makefile
TOP = tb_axi4_to_axi3_wr

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_axi4_to_axi3_wr.sv
`timescale 1ns/1ps

module tb_axi4_to_axi3_wr;

  localparam int NUM_BURSTS = 40;
  localparam int CYCLE_LIMIT = NUM_BURSTS * 256 * 4 + 2000;  // longest bursts, heavy stalls.

  logic ACLK;
  logic ARESET;
  logic [axi_types_pkg::ID_W-1:0] s_awid, s_bid, m_awid, m_wid, m_bid;
  logic [axi_types_pkg::ADDR_W-1:0] s_awaddr, m_awaddr;
  logic [conv_cfg_pkg::AXI4_LEN_W-1:0] s_awlen;
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0] m_awlen;
  logic [axi_types_pkg::DATA_W-1:0] s_wdata, m_wdata;
  logic [axi_types_pkg::STRB_W-1:0] s_wstrb, m_wstrb;
  logic s_awvalid, s_awready, s_wlast, s_wvalid, s_wready, s_bvalid, s_bready;
  logic m_awvalid, m_awready, m_wlast, m_wvalid, m_wready, m_bvalid, m_bready;
  axi_types_pkg::resp_e s_bresp, m_bresp;

  integer seed;
  int n_errors, n_checks, cycle_cnt, b_seen, w_seen, total_beats;
  int aw_b, w_b, w_k;
  logic aw_fire, w_fire, mb_fire;  // handshakes seen at the last rising edge.
  logic [7:0] burst_len [NUM_BURSTS];
  logic [31:0] burst_addr [NUM_BURSTS];
  logic [3:0] burst_id [NUM_BURSTS];
  logic [39:0] exp_aw_q [$];  // {id, len, addr}.
  logic [40:0] exp_w_q [$];   // {id, last, strb, data}.
  logic [39:0] exp_aw;
  logic [40:0] exp_w;
  logic [3:0] exp_b_id_q [$];
  int exp_b_cnt_q [$];
  logic [3:0] b_pending_q [$];
  axi_types_pkg::resp_e resp_q [$];
  axi_types_pkg::resp_e worst;

  axi4_to_axi3_wr dut_i (.*);

  always #2 ACLK = ~ACLK;

  function automatic logic [31:0] beat_data(input int b, input int k);
    return {b[7:0], k[7:0], 8'hc3 ^ k[7:0], 8'h3c ^ b[7:0]};
  endfunction

  function automatic logic [3:0] beat_strb(input int b, input int k);
    return 4'(b + 3 * k) | 4'b0001;
  endfunction

  function automatic int resp_rank(input axi_types_pkg::resp_e r);
    if (r == axi_types_pkg::RESP_DECERR) return 2;
    if (r == axi_types_pkg::RESP_SLVERR) return 1;
    return 0;
  endfunction

  // expected axi3 pieces and beats of one burst, returns the piece count.
  function automatic int split_ref(input int b, input logic [3:0] id,
                                   input logic [31:0] addr, input logic [7:0] len);
    int rem;
    int plen;
    int beat;
    int pieces;
    logic [31:0] a;
    rem = int'(len) + 1;
    a = addr;
    beat = 0;
    pieces = 0;
    while (rem > 0) begin
      plen = (rem > conv_cfg_pkg::AXI3_MAX_BEATS) ? conv_cfg_pkg::AXI3_MAX_BEATS : rem;
      exp_aw_q.push_back({id, 4'(plen - 1), a});
      for (int i = 0; i < plen; i++) begin
        exp_w_q.push_back({id, i == plen - 1, beat_strb(b, beat), beat_data(b, beat)});
        beat++;
      end
      a = a + 32'(conv_cfg_pkg::AXI3_MAX_BEATS * axi_types_pkg::BEAT_BYTES);
      rem = rem - plen;
      pieces++;
    end
    return pieces;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  initial begin
    seed = 32'ha7db56c7;
    {n_errors, n_checks, b_seen, w_seen, total_beats, aw_b, w_b, w_k} = '0;
    {aw_fire, w_fire, mb_fire} = '0;
    ACLK = 1'b0;
    ARESET = 1'b1;
    {s_awid, s_awaddr, s_awlen, s_awvalid} = '0;
    {s_wdata, s_wstrb, s_wlast, s_wvalid, s_bready} = '0;
    {m_awready, m_wready, m_bid, m_bvalid} = '0;
    m_bresp = axi_types_pkg::RESP_OKAY;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      case (b)
        0: burst_len[b] = 8'd0;  // 1, 16, 17 and 256 beats first.
        1: burst_len[b] = 8'd15;
        2: burst_len[b] = 8'd16;
        3: burst_len[b] = 8'd255;
        default: burst_len[b] = 8'($random(seed));
      endcase
      burst_addr[b] = 32'($random(seed)) & 32'hffff_fffc;
      burst_id[b] = 4'(b);
      exp_b_id_q.push_back(burst_id[b]);
      exp_b_cnt_q.push_back(split_ref(b, burst_id[b], burst_addr[b], burst_len[b]));
      total_beats += int'(burst_len[b]) + 1;
    end
    repeat (2) @(posedge ACLK);
    @(negedge ACLK);
    ARESET <= 1'b0;
    wait (b_seen == NUM_BURSTS);
    repeat (20) @(posedge ACLK);
    compare_value("m_w beat count", w_seen, total_beats);
    compare_value("m_aw pieces left", exp_aw_q.size(), 0);
    compare_value("m_b responses left", resp_q.size(), 0);
    $display("checks %0d, errors %0d, assertion failures %0d",
             n_checks, n_errors, dut_i.checker_i.fails);
    if (n_errors == 0 && dut_i.checker_i.fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge ACLK);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: bursts did not complete within %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  // master, slave readies and slave responses.
  always @(negedge ACLK) begin
    if (!ARESET) begin
      m_awready = ($random(seed) & 3) != 0;
      m_wready = ($random(seed) & 3) != 0;
      s_bready = ($random(seed) & 1) != 0;
      if (aw_fire) begin
        s_awvalid = 1'b0;
        aw_b++;
      end
      if (!s_awvalid && aw_b < NUM_BURSTS) begin
        s_awvalid = 1'b1;
        s_awid = burst_id[aw_b];
        s_awaddr = burst_addr[aw_b];
        s_awlen = burst_len[aw_b];
      end
      if (w_fire) begin
        s_wvalid = 1'b0;
        w_k++;
        if (w_k > int'(burst_len[w_b])) begin
          w_b++;
          w_k = 0;
        end
      end
      if (!s_wvalid && w_b < NUM_BURSTS && ($random(seed) & 3) != 0) begin
        s_wvalid = 1'b1;
        s_wdata = beat_data(w_b, w_k);
        s_wstrb = beat_strb(w_b, w_k);
        s_wlast = (w_k == int'(burst_len[w_b]));
      end
      if (mb_fire) m_bvalid = 1'b0;
      if (!m_bvalid && b_pending_q.size() != 0) begin
        m_bvalid = 1'b1;
        m_bid = b_pending_q.pop_front();
        m_bresp = (($random(seed) & 7) == 0) ? axi_types_pkg::RESP_SLVERR
                                             : axi_types_pkg::RESP_OKAY;
      end
    end
  end

  // compare process.
  always @(posedge ACLK) begin
    aw_fire = !ARESET && s_awvalid && s_awready;
    w_fire = !ARESET && s_wvalid && s_wready;
    mb_fire = !ARESET && m_bvalid && m_bready;
    if (!ARESET && m_awvalid && m_awready) begin
      if (exp_aw_q.size() == 0) begin
        n_errors++;
        $display("m_aw transfer with no piece left to send");
      end else begin
        exp_aw = exp_aw_q.pop_front();
        compare_value("m_awid", m_awid, exp_aw[39:36]);
        compare_value("m_awlen", m_awlen, exp_aw[35:32]);
        compare_value("m_awaddr", m_awaddr, exp_aw[31:0]);
      end
    end
    if (!ARESET && m_wvalid && m_wready) begin
      w_seen++;
      if (exp_w_q.size() == 0) begin
        n_errors++;
        $display("m_w beat arrived after all expected beats");
      end else begin
        exp_w = exp_w_q.pop_front();
        compare_value("m_wid", m_wid, exp_w[40:37]);
        compare_value("m_wlast", m_wlast, exp_w[36]);
        compare_value("m_wstrb", m_wstrb, exp_w[35:32]);
        compare_value("m_wdata", m_wdata, exp_w[31:0]);
      end
      if (m_wlast) b_pending_q.push_back(m_wid);  // slave answers once per piece.
    end
    if (mb_fire) resp_q.push_back(m_bresp);
    if (!ARESET && s_bvalid && s_bready) begin
      b_seen++;
      if (exp_b_id_q.size() == 0) begin
        n_errors++;
        $display("s_b response with no burst outstanding");
      end else begin
        worst = axi_types_pkg::RESP_OKAY;
        repeat (exp_b_cnt_q.pop_front()) begin
          if (resp_q.size() == 0) begin
            n_errors++;
            $display("s_b response before all piece responses were taken");
          end else if (resp_rank(resp_q[0]) > resp_rank(worst)) begin
            worst = resp_q.pop_front();
          end else begin
            void'(resp_q.pop_front());
          end
        end
        compare_value("s_bid", s_bid, exp_b_id_q.pop_front());
        compare_value("s_bresp", s_bresp, worst);
      end
    end
  end

endmodule

// File: tests/wr_conv_checker.sv
`timescale 1ns/1ps

module wr_conv_checker (
  input logic                                ACLK,
  input logic                                ARESET,
  input logic [axi_types_pkg::ID_W-1:0]      m_awid,
  input logic [axi_types_pkg::ADDR_W-1:0]    m_awaddr,
  input logic [conv_cfg_pkg::AXI3_LEN_W-1:0] m_awlen,
  input logic                                m_awvalid,
  input logic                                m_awready,
  input logic [axi_types_pkg::ID_W-1:0]      m_wid,
  input logic [axi_types_pkg::DATA_W-1:0]    m_wdata,
  input logic [axi_types_pkg::STRB_W-1:0]    m_wstrb,
  input logic                                m_wlast,
  input logic                                m_wvalid,
  input logic                                m_wready,
  input logic [axi_types_pkg::ID_W-1:0]      s_bid,
  input axi_types_pkg::resp_e                s_bresp,
  input logic                                s_bvalid,
  input logic                                s_bready
);

  int unsigned fails;
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0] w_beats;  // beats since the last wlast.

  initial fails = 0;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      w_beats <= '0;
    end else if (m_wvalid && m_wready) begin
      w_beats <= m_wlast ? '0 : w_beats + 1'b1;
    end
  end

  aw_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m_awvalid && !m_awready |=> m_awvalid && $stable({m_awid, m_awaddr, m_awlen}))
    else begin
      fails++;
      $error("m_aw dropped or changed while stalled");
    end

  w_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && !m_wready |=> m_wvalid && $stable({m_wid, m_wdata, m_wstrb, m_wlast}))
    else begin
      fails++;
      $error("m_w dropped or changed while stalled");
    end

  b_hold: assert property (@(posedge ACLK) disable iff (ARESET)
    s_bvalid && !s_bready |=> s_bvalid && $stable({s_bid, s_bresp}))
    else begin
      fails++;
      $error("s_b dropped or changed while stalled");
    end

  // axi3 bursts top out at 16 beats.
  wlast_max: assert property (@(posedge ACLK) disable iff (ARESET)
    m_wvalid && w_beats == 4'(conv_cfg_pkg::AXI3_MAX_BEATS - 1) |-> m_wlast)
    else begin
      fails++;
      $error("m_w piece longer than the axi3 limit");
    end

  b_after_reset: assert property (@(posedge ACLK) ARESET |=> !s_bvalid)
    else begin
      fails++;
      $error("s_bvalid high right after reset");
    end

endmodule

bind axi4_to_axi3_wr wr_conv_checker checker_i (.*);

// File: rtl/axi4_to_axi3_wr.sv
`timescale 1ns/1ps

module axi4_to_axi3_wr (
  input  logic                                 ACLK,
  input  logic                                 ARESET,
  input  logic [axi_types_pkg::ID_W-1:0]       s_awid,
  input  logic [axi_types_pkg::ADDR_W-1:0]     s_awaddr,
  input  logic [conv_cfg_pkg::AXI4_LEN_W-1:0]  s_awlen,
  input  logic                                 s_awvalid,
  output logic                                 s_awready,
  input  logic [axi_types_pkg::DATA_W-1:0]     s_wdata,
  input  logic [axi_types_pkg::STRB_W-1:0]     s_wstrb,
  input  logic                                 s_wlast,
  input  logic                                 s_wvalid,
  output logic                                 s_wready,
  output logic [axi_types_pkg::ID_W-1:0]       s_bid,
  output axi_types_pkg::resp_e                 s_bresp,
  output logic                                 s_bvalid,
  input  logic                                 s_bready,
  output logic [axi_types_pkg::ID_W-1:0]       m_awid,
  output logic [axi_types_pkg::ADDR_W-1:0]     m_awaddr,
  output logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  m_awlen,
  output logic                                 m_awvalid,
  input  logic                                 m_awready,
  output logic [axi_types_pkg::ID_W-1:0]       m_wid,
  output logic [axi_types_pkg::DATA_W-1:0]     m_wdata,
  output logic [axi_types_pkg::STRB_W-1:0]     m_wstrb,
  output logic                                 m_wlast,
  output logic                                 m_wvalid,
  input  logic                                 m_wready,
  input  logic [axi_types_pkg::ID_W-1:0]       m_bid,
  input  axi_types_pkg::resp_e                 m_bresp,
  input  logic                                 m_bvalid,
  output logic                                 m_bready
);

  logic                                 wcmd_push;
  logic [axi_types_pkg::ID_W-1:0]       wcmd_id;
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  wcmd_len;
  logic                                 wcmd_full;
  logic                                 cmd_valid;
  logic [axi_types_pkg::ID_W-1:0]       cmd_id;
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  cmd_length;
  logic                                 cmd_ready;
  logic                                 bcmd_push;
  logic [axi_types_pkg::ID_W-1:0]       bcmd_id;
  logic [conv_cfg_pkg::PIECE_CNT_W-1:0] bcmd_pieces;
  logic                                 bcmd_full;

  aw_burst_splitter splitter_i (
    .ACLK(ACLK), .ARESET(ARESET),
    .s_awid(s_awid), .s_awaddr(s_awaddr), .s_awlen(s_awlen),
    .s_awvalid(s_awvalid), .s_awready(s_awready),
    .m_awid(m_awid), .m_awaddr(m_awaddr), .m_awlen(m_awlen),
    .m_awvalid(m_awvalid), .m_awready(m_awready),
    .wcmd_push(wcmd_push), .wcmd_id(wcmd_id), .wcmd_len(wcmd_len), .wcmd_full(wcmd_full),
    .bcmd_push(bcmd_push), .bcmd_id(bcmd_id), .bcmd_pieces(bcmd_pieces),
    .bcmd_full(bcmd_full)
  );

  w_cmd_queue w_queue_i (
    .ACLK(ACLK), .ARESET(ARESET),
    .wcmd_push(wcmd_push), .wcmd_id(wcmd_id), .wcmd_len(wcmd_len), .wcmd_full(wcmd_full),
    .cmd_valid(cmd_valid), .cmd_id(cmd_id), .cmd_length(cmd_length), .cmd_ready(cmd_ready)
  );

  w_axi3_conv w_conv_i (
    .ACLK(ACLK), .ARESET(ARESET),
    .cmd_valid(cmd_valid), .cmd_id(cmd_id), .cmd_length(cmd_length), .cmd_ready(cmd_ready),
    .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wlast(s_wlast),
    .s_wvalid(s_wvalid), .s_wready(s_wready),
    .m_wid(m_wid), .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_wlast(m_wlast),
    .m_wvalid(m_wvalid), .m_wready(m_wready)
  );

  b_resp_merger b_merge_i (
    .ACLK(ACLK), .ARESET(ARESET),
    .bcmd_push(bcmd_push), .bcmd_id(bcmd_id), .bcmd_pieces(bcmd_pieces),
    .bcmd_full(bcmd_full),
    .m_bid(m_bid), .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready)
  );

endmodule

// File: rtl/b_resp_merger.sv
`timescale 1ns/1ps

module b_resp_merger (
  input  logic                                  ACLK,
  input  logic                                  ARESET,
  input  logic                                  bcmd_push,
  input  logic [axi_types_pkg::ID_W-1:0]        bcmd_id,
  input  logic [conv_cfg_pkg::PIECE_CNT_W-1:0]  bcmd_pieces,
  output logic                                  bcmd_full,
  input  logic [axi_types_pkg::ID_W-1:0]        m_bid,
  input  axi_types_pkg::resp_e                  m_bresp,
  input  logic                                  m_bvalid,
  output logic                                  m_bready,
  output logic [axi_types_pkg::ID_W-1:0]        s_bid,
  output axi_types_pkg::resp_e                  s_bresp,
  output logic                                  s_bvalid,
  input  logic                                  s_bready
);

  logic [axi_types_pkg::ID_W-1:0]         id_mem  [conv_cfg_pkg::B_CMD_DEPTH];
  logic [conv_cfg_pkg::PIECE_CNT_W-1:0]   cnt_mem [conv_cfg_pkg::B_CMD_DEPTH];
  logic [$clog2(conv_cfg_pkg::B_CMD_DEPTH)-1:0] wr_ptr;
  logic [$clog2(conv_cfg_pkg::B_CMD_DEPTH)-1:0] rd_ptr;
  logic [$clog2(conv_cfg_pkg::B_CMD_DEPTH):0]   q_count;
  logic [conv_cfg_pkg::PIECE_CNT_W-1:0]   resp_cnt;   // responses seen for head burst.
  logic [conv_cfg_pkg::PIECE_CNT_W-1:0]   cnt_next;
  axi_types_pkg::resp_e                   worst;
  axi_types_pkg::resp_e                   merged;
  logic                                   b_take;
  logic                                   b_last;

  // decerr outranks slverr, which outranks the okay codes.
  function automatic axi_types_pkg::resp_e worse_resp(input axi_types_pkg::resp_e a,
                                                      input axi_types_pkg::resp_e b);
    if (a == axi_types_pkg::RESP_DECERR || b == axi_types_pkg::RESP_DECERR) begin
      return axi_types_pkg::RESP_DECERR;
    end
    if (a == axi_types_pkg::RESP_SLVERR || b == axi_types_pkg::RESP_SLVERR) begin
      return axi_types_pkg::RESP_SLVERR;
    end
    return a;
  endfunction

  assign bcmd_full = (q_count == conv_cfg_pkg::B_CMD_DEPTH);
  assign m_bready = ~s_bvalid & (q_count != '0);
  assign b_take = m_bvalid & m_bready;
  assign cnt_next = resp_cnt + 1'b1;
  assign merged = worse_resp(worst, m_bresp);
  assign b_last = b_take & (cnt_next == cnt_mem[rd_ptr]);

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_count <= '0;
      resp_cnt <= '0;
      worst <= axi_types_pkg::RESP_OKAY;
      s_bvalid <= 1'b0;
    end else begin
      if (bcmd_push) wr_ptr <= wr_ptr + 1'b1;
      if (b_last) rd_ptr <= rd_ptr + 1'b1;  // head burst complete.
      case ({bcmd_push, b_last})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      if (b_last) begin
        resp_cnt <= '0;
        worst <= axi_types_pkg::RESP_OKAY;
      end else if (b_take) begin
        resp_cnt <= cnt_next;
        worst <= merged;
      end
      if (b_last) begin
        s_bvalid <= 1'b1;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (bcmd_push) begin
      id_mem[wr_ptr] <= bcmd_id;
      cnt_mem[wr_ptr] <= bcmd_pieces;
    end
    if (b_last) begin
      s_bid <= id_mem[rd_ptr];  // same as m_bid, responses arrive in order.
      s_bresp <= merged;
    end
  end

endmodule

// File: rtl/w_axi3_conv.sv
`timescale 1ns/1ps

module w_axi3_conv (
  input  logic                                 ACLK,
  input  logic                                 ARESET,
  input  logic                                 cmd_valid,
  input  logic [axi_types_pkg::ID_W-1:0]       cmd_id,
  input  logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  cmd_length,
  output logic                                 cmd_ready,
  input  logic [axi_types_pkg::DATA_W-1:0]     s_wdata,
  input  logic [axi_types_pkg::STRB_W-1:0]     s_wstrb,
  input  logic                                 s_wlast,
  input  logic                                 s_wvalid,
  output logic                                 s_wready,
  output logic [axi_types_pkg::ID_W-1:0]       m_wid,
  output logic [axi_types_pkg::DATA_W-1:0]     m_wdata,
  output logic [axi_types_pkg::STRB_W-1:0]     m_wstrb,
  output logic                                 m_wlast,
  output logic                                 m_wvalid,
  input  logic                                 m_wready
);

  logic                                first_beat;  // next beat opens a piece.
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0] beat_cnt;
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0] cur_cnt;
  logic                                stalling;
  logic                                beat_done;

  assign m_wvalid = s_wvalid & cmd_valid;
  assign stalling = m_wvalid & ~m_wready;
  assign s_wready = s_wvalid & cmd_valid & ~stalling;
  assign beat_done = m_wvalid & m_wready;

  assign cur_cnt = first_beat ? cmd_length : beat_cnt;
  // wlast comes from the piece length; the master's s_wlast marks the axi4 burst only.
  assign m_wlast = (cur_cnt == '0);
  assign cmd_ready = beat_done & m_wlast;

  assign m_wid = cmd_id;
  assign m_wdata = s_wdata;
  assign m_wstrb = s_wstrb;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_beat <= 1'b1;
      beat_cnt <= '0;
    end else if (beat_done) begin
      first_beat <= m_wlast;
      beat_cnt <= cur_cnt - 1'b1;
    end
  end

endmodule

// File: rtl/w_cmd_queue.sv
`timescale 1ns/1ps

module w_cmd_queue (
  input  logic                                 ACLK,
  input  logic                                 ARESET,
  input  logic                                 wcmd_push,
  input  logic [axi_types_pkg::ID_W-1:0]       wcmd_id,
  input  logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  wcmd_len,
  output logic                                 wcmd_full,
  output logic                                 cmd_valid,
  output logic [axi_types_pkg::ID_W-1:0]       cmd_id,
  output logic [conv_cfg_pkg::AXI3_LEN_W-1:0]  cmd_length,
  input  logic                                 cmd_ready
);

  logic [axi_types_pkg::ID_W-1:0]         id_mem  [conv_cfg_pkg::W_CMD_DEPTH];
  logic [conv_cfg_pkg::AXI3_LEN_W-1:0]    len_mem [conv_cfg_pkg::W_CMD_DEPTH];
  logic [$clog2(conv_cfg_pkg::W_CMD_DEPTH)-1:0] wr_ptr;
  logic [$clog2(conv_cfg_pkg::W_CMD_DEPTH)-1:0] rd_ptr;
  logic [$clog2(conv_cfg_pkg::W_CMD_DEPTH):0]   count;

  assign wcmd_full = (count == conv_cfg_pkg::W_CMD_DEPTH);
  assign cmd_valid = (count != '0);
  assign cmd_id = id_mem[rd_ptr];
  assign cmd_length = len_mem[rd_ptr];

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wcmd_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
      end
      if (cmd_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wcmd_push, cmd_ready})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (wcmd_push) begin
      id_mem[wr_ptr] <= wcmd_id;
      len_mem[wr_ptr] <= wcmd_len;
    end
  end

endmodule

// File: rtl/aw_burst_splitter.sv
`timescale 1ns/1ps

module aw_burst_splitter (
  input  logic                                   ACLK,
  input  logic                                   ARESET,
  input  logic [axi_types_pkg::ID_W-1:0]         s_awid,
  input  logic [axi_types_pkg::ADDR_W-1:0]       s_awaddr,
  input  logic [conv_cfg_pkg::AXI4_LEN_W-1:0]    s_awlen,
  input  logic                                   s_awvalid,
  output logic                                   s_awready,
  output logic [axi_types_pkg::ID_W-1:0]         m_awid,
  output logic [axi_types_pkg::ADDR_W-1:0]       m_awaddr,
  output logic [conv_cfg_pkg::AXI3_LEN_W-1:0]    m_awlen,
  output logic                                   m_awvalid,
  input  logic                                   m_awready,
  output logic                                   wcmd_push,
  output logic [axi_types_pkg::ID_W-1:0]         wcmd_id,
  output logic [conv_cfg_pkg::AXI3_LEN_W-1:0]    wcmd_len,
  input  logic                                   wcmd_full,
  output logic                                   bcmd_push,
  output logic [axi_types_pkg::ID_W-1:0]         bcmd_id,
  output logic [conv_cfg_pkg::PIECE_CNT_W-1:0]   bcmd_pieces,
  input  logic                                   bcmd_full
);

  conv_cfg_pkg::split_state_e            state;
  logic [conv_cfg_pkg::AXI4_LEN_W:0]     rem_beats;  // beats not yet issued.
  logic [conv_cfg_pkg::AXI4_LEN_W:0]     rem_minus_one;
  logic                                  last_piece;
  logic                                  aw_accept;
  logic                                  piece_done;

  assign s_awready = (state == conv_cfg_pkg::SPLIT_IDLE) & ~wcmd_full & ~bcmd_full;
  assign aw_accept = s_awvalid & s_awready;

  // only the splitter fills the w queue, so full cannot rise while a piece waits.
  assign m_awvalid = (state == conv_cfg_pkg::SPLIT_ISSUE) & ~wcmd_full;
  assign piece_done = m_awvalid & m_awready;

  assign rem_minus_one = rem_beats - 1'b1;
  assign last_piece = (rem_beats <= conv_cfg_pkg::AXI3_MAX_BEATS);
  assign m_awlen = last_piece ? rem_minus_one[conv_cfg_pkg::AXI3_LEN_W-1:0]
                              : {conv_cfg_pkg::AXI3_LEN_W{1'b1}};

  assign wcmd_push = piece_done;  // one w command per piece.
  assign wcmd_id = m_awid;
  assign wcmd_len = m_awlen;

  // piece count is len/16 rounded up over len+1 beats.
  assign bcmd_push = aw_accept;
  assign bcmd_id = s_awid;
  assign bcmd_pieces = {1'b0, s_awlen[conv_cfg_pkg::AXI4_LEN_W-1:conv_cfg_pkg::AXI3_LEN_W]}
                       + 1'b1;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state <= conv_cfg_pkg::SPLIT_IDLE;
      rem_beats <= '0;
    end else begin
      case (state)
        conv_cfg_pkg::SPLIT_IDLE: begin
          if (aw_accept) begin
            state <= conv_cfg_pkg::SPLIT_ISSUE;
            rem_beats <= {1'b0, s_awlen} + 1'b1;
          end
        end
        conv_cfg_pkg::SPLIT_ISSUE: begin
          if (piece_done) begin
            if (last_piece) begin
              state <= conv_cfg_pkg::SPLIT_IDLE;
            end
            rem_beats <= rem_beats - {1'b0, m_awlen} - 1'b1;
          end
        end
        default: state <= conv_cfg_pkg::SPLIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (aw_accept) begin
      m_awid <= s_awid;
      m_awaddr <= s_awaddr;
    end else if (piece_done) begin
      // next 16-beat window.
      m_awaddr <= m_awaddr + conv_cfg_pkg::AXI3_MAX_BEATS * axi_types_pkg::BEAT_BYTES;
    end
  end

endmodule

// File: rtl/conv_cfg_pkg.sv
package conv_cfg_pkg;

  // axi3 caps a burst at 16 beats.
  localparam int AXI3_MAX_BEATS = 16;
  localparam int AXI3_LEN_W = 4;
  localparam int AXI4_LEN_W = 8;

  localparam int PIECE_CNT_W = 5;  // counts 1..16 pieces.

  localparam int W_CMD_DEPTH = 4;
  localparam int B_CMD_DEPTH = 4;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_ISSUE
  } split_state_e;

endpackage

// File: rtl/axi_types_pkg.sv
package axi_types_pkg;

  localparam int ID_W = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // one strobe per byte.
  localparam int BEAT_BYTES = STRB_W;

  // write response codes, same encoding on both sides.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage
